/* periph_pkg.sv */
//##########################################################################
// Shared types and constants of the XT peripheral block
// Decoded bus selects, EMS page entries, I/O port addresses,
// EMS window bases and bus widths
//##########################################################################

package periph_pkg;

    // Bus widths
    localparam int ADDR_W    = 20;
    localparam int DATA_W    = 8;
    localparam int BLK_COUNT = 8;
    localparam int PAGE_W    = 7;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] byte_t;

    // Decoded view of one ISA bus cycle, all active high
    typedef struct packed {
        // One per 32-port block: 0 DMA, 1 PIC, 2 PIT, 3 PPI, 4 DMA page
        logic [BLK_COUNT-1:0] blk_sel;
        logic                 ems_sel;
        logic                 lpt_sel;
        logic                 nmi_sel;
        // Any I/O strobe, with or without address enable
        logic                 iorq;
        logic                 rd;
        logic                 wr;
    } bus_sel_t;

    // One EMS page map entry
    typedef struct packed {
        logic              ena;
        logic [PAGE_W-1:0] page;
    } ems_entry_t;

    // I/O port addresses
    localparam logic [15:0] EMS_PORT_BASE = 16'h0260;
    localparam logic [15:0] LPT_PORT      = 16'h0378;
    localparam logic [15:0] NMI_PORT_BASE = 16'h00A0;

    // High nibble of the EMS window base
    localparam logic [3:0] EMS_WINDOW_A = 4'hA;
    localparam logic [3:0] EMS_WINDOW_C = 4'hC;
    localparam logic [3:0] EMS_WINDOW_D = 4'hD;

    // Four 16 KB pages fill one 64 KB window
    localparam int EMS_ENTRIES = 4;

    // Written to unmap a page, and read back from an unmapped one
    localparam byte_t EMS_UNMAPPED = 8'hFF;

    // Power-up value of the LPT and NMI latches
    localparam byte_t LATCH_RESET = 8'hFF;

endpackage

/* port_decode.sv */
//##########################################################################
// ISA I/O port decoder
// Block selects for ports 000h-0FFh and register selects for EMS,
// LPT and the Tandy NMI mask
//##########################################################################

`timescale 1ns/1ps

module port_decode (
    input  periph_pkg::addr_t    address_i,
    input  logic                 address_enable_n_i,
    input  logic                 io_read_n_i,
    input  logic                 io_write_n_i,
    input  logic                 ems_enabled_i,
    input  logic                 tandy_video_i,
    output periph_pkg::bus_sel_t sel_o
);

    logic                             iorq;
    logic                             io_cycle;
    logic [15:0]                      port;
    logic [periph_pkg::BLK_COUNT-1:0] blk_onehot;
    logic                             ems_port_hit;
    logic                             lpt_port_hit;
    logic                             nmi_port_hit;

    assign port = address_i[15:0];
    assign iorq = ~io_read_n_i | ~io_write_n_i;

    // CPU I/O cycle, not a DMA transfer
    assign io_cycle = iorq & ~address_enable_n_i;

    // Motherboard devices sit below 100h in blocks of 32 ports
    always_comb begin
        blk_onehot = '0;
        if (io_cycle && (address_i[9:8] == 2'b00)) begin
            blk_onehot[address_i[7:5]] = 1'b1;
        end
    end

    // 260h-263h, one port per page entry
    assign ems_port_hit = (port[15:2] == periph_pkg::EMS_PORT_BASE[15:2]);

    assign lpt_port_hit = (port == periph_pkg::LPT_PORT);

    // 0A0h-0A7h mirror the same register
    assign nmi_port_hit = (port[15:3] == periph_pkg::NMI_PORT_BASE[15:3]);

    always_comb begin
        sel_o         = '0;
        sel_o.blk_sel = blk_onehot;
        sel_o.ems_sel = io_cycle & ems_enabled_i & ems_port_hit;
        sel_o.lpt_sel = io_cycle & lpt_port_hit;
        // NMI mask register only exists on the Tandy
        sel_o.nmi_sel = io_cycle & tandy_video_i & nmi_port_hit;
        sel_o.iorq    = iorq;
        sel_o.rd      = ~io_read_n_i;
        sel_o.wr      = ~io_write_n_i;
    end

endmodule

/* io_reg_bank.sv */
//##########################################################################
// Indexed register bank for any packed payload
// One indexed write per cycle, asynchronous reset to a given value
//##########################################################################

`timescale 1ns/1ps

module io_reg_bank #(
    parameter type      payload_t   = periph_pkg::byte_t,
    parameter int       DEPTH       = 2,
    parameter payload_t RESET_VALUE = '0,
    localparam int      IDX_W       = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 wr_en_i,
    input  logic [IDX_W-1:0]     wr_index_i,
    input  payload_t             wr_data_i,
    output payload_t [DEPTH-1:0] entries_o
);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries_o[i] <= RESET_VALUE;
            end
        end
        else if (wr_en_i) begin
            entries_o[wr_index_i] <= wr_data_i;
        end
    end

endmodule

/* ems_mapper.sv */
//##########################################################################
// EMS page mapper
// Write staging, page entry storage and memory window strobes
//##########################################################################

`timescale 1ns/1ps

module ems_mapper #(
    parameter int  ENTRIES = periph_pkg::EMS_ENTRIES,
    localparam int IDX_W   = $clog2(ENTRIES)
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  periph_pkg::bus_sel_t                  sel_i,
    input  periph_pkg::addr_t                     address_i,
    input  periph_pkg::byte_t                     data_i,
    input  logic [1:0]                            ems_base_i,
    output periph_pkg::ems_entry_t [ENTRIES-1:0]  entries_o,
    output logic [ENTRIES-1:0]                    ems_window_o
);

    periph_pkg::ems_entry_t cur_entry;
    periph_pkg::ems_entry_t next_entry;
    logic                   stage_wr;
    logic [IDX_W-1:0]       stage_index;
    periph_pkg::ems_entry_t stage_entry;
    logic [3:0]             window_base;

    assign cur_entry = entries_o[address_i[IDX_W-1:0]];

    // FFh unmaps, below 80h maps, anything else keeps the entry
    always_comb begin
        if (data_i == periph_pkg::EMS_UNMAPPED) begin
            next_entry.ena  = 1'b0;
            next_entry.page = '1;
        end
        else if (~data_i[7]) begin
            next_entry.ena  = 1'b1;
            next_entry.page = data_i[periph_pkg::PAGE_W-1:0];
        end
        else begin
            next_entry = cur_entry;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset)
            stage_wr <= 1'b0;
        else
            stage_wr <= sel_i.ems_sel & sel_i.wr;
    end

    // Held for one cycle, committed on the next edge
    always_ff @(posedge clock) begin
        stage_index <= address_i[IDX_W-1:0];
        stage_entry <= next_entry;
    end

    io_reg_bank #(
        .payload_t   (periph_pkg::ems_entry_t),
        .DEPTH       (ENTRIES),
        .RESET_VALUE ('0)
    ) u_ems_bank (
        .clock       (clock),
        .reset       (reset),
        .wr_en_i     (stage_wr),
        .wr_index_i  (stage_index),
        .wr_data_i   (stage_entry),
        .entries_o   (entries_o)
    );

    always_comb begin
        case (ems_base_i)
            2'b00:   window_base = periph_pkg::EMS_WINDOW_A;
            2'b01:   window_base = periph_pkg::EMS_WINDOW_C;
            default: window_base = periph_pkg::EMS_WINDOW_D;
        endcase
    end

    // Page k covers the k-th 16 KB slot of the 64 KB window
    for (genvar k = 0; k < ENTRIES; k++) begin : g_window
        assign ems_window_o[k] = entries_o[k].ena & ~sel_i.iorq
                               & (address_i[19:14] == {window_base, 2'(k)});
    end

endmodule

/* readback_mux.sv */
//##########################################################################
// CPU read-back of the system registers
// EMS entries first, then the LPT latch, then the NMI mask latch
//##########################################################################

`timescale 1ns/1ps

module readback_mux #(
    parameter int  ENTRIES = periph_pkg::EMS_ENTRIES,
    localparam int IDX_W   = $clog2(ENTRIES)
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  periph_pkg::bus_sel_t                 sel_i,
    input  periph_pkg::addr_t                    address_i,
    input  periph_pkg::ems_entry_t [ENTRIES-1:0] ems_entries_i,
    input  periph_pkg::byte_t                    lpt_i,
    input  periph_pkg::byte_t                    nmi_i,
    output periph_pkg::byte_t                    data_bus_out_o,
    output logic                                 data_bus_out_from_chipset_o
);

    periph_pkg::ems_entry_t ems_entry;
    periph_pkg::byte_t      ems_value;

    assign ems_entry = ems_entries_i[address_i[IDX_W-1:0]];

    // Unmapped pages read as FFh
    assign ems_value = ems_entry.ena ? periph_pkg::byte_t'(ems_entry.page)
                                     : periph_pkg::EMS_UNMAPPED;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_bus_out_from_chipset_o <= 1'b0;
            data_bus_out_o              <= '0;
        end
        else if (sel_i.rd && sel_i.ems_sel) begin
            data_bus_out_from_chipset_o <= 1'b1;
            data_bus_out_o              <= ems_value;
        end
        else if (sel_i.rd && sel_i.lpt_sel) begin
            data_bus_out_from_chipset_o <= 1'b1;
            data_bus_out_o              <= lpt_i;
        end
        else if (sel_i.rd && sel_i.nmi_sel) begin
            data_bus_out_from_chipset_o <= 1'b1;
            data_bus_out_o              <= nmi_i;
        end
        else begin
            // Nobody drives the bus
            data_bus_out_from_chipset_o <= 1'b0;
            data_bus_out_o              <= '0;
        end
    end

endmodule

/* periph_top.sv */
//##########################################################################
// XT peripheral block, I/O decode and system registers
// Port decoder, LPT and NMI latches, EMS mapper and read-back
//##########################################################################

`timescale 1ns/1ps

module periph_top #(
    parameter int EMS_ENTRIES = periph_pkg::EMS_ENTRIES
) (
    input  logic                             clock,
    input  logic                             reset,
    // ISA bus
    input  periph_pkg::addr_t                address_i,
    input  logic                             address_enable_n_i,
    input  logic                             io_read_n_i,
    input  logic                             io_write_n_i,
    input  periph_pkg::byte_t                data_i,
    // Configuration
    input  logic                             ems_enabled_i,
    input  logic [1:0]                       ems_base_i,
    input  logic                             tandy_video_i,
    // Decoded selects and strobes
    output logic [periph_pkg::BLK_COUNT-1:0] blk_sel_n_o,
    output logic [EMS_ENTRIES-1:0]           ems_window_o,
    // CPU read-back
    output periph_pkg::byte_t                data_bus_out_o,
    output logic                             data_bus_out_from_chipset_o
);

    localparam int LATCH_DEPTH = 2;
    localparam int LATCH_LPT   = 0;
    localparam int LATCH_NMI   = 1;

    periph_pkg::bus_sel_t                     sel;
    logic                                     latch_wr;
    logic                                     latch_index;
    periph_pkg::byte_t [LATCH_DEPTH-1:0]      latches;
    periph_pkg::ems_entry_t [EMS_ENTRIES-1:0] ems_entries;

    port_decode u_port_decode (
        .address_i          (address_i),
        .address_enable_n_i (address_enable_n_i),
        .io_read_n_i        (io_read_n_i),
        .io_write_n_i       (io_write_n_i),
        .ems_enabled_i      (ems_enabled_i),
        .tandy_video_i      (tandy_video_i),
        .sel_o              (sel)
    );

    // Chip selects for the motherboard devices are active low
    assign blk_sel_n_o = ~sel.blk_sel;

    // LPT data and NMI mask share one bank
    assign latch_wr    = (sel.lpt_sel | sel.nmi_sel) & sel.wr;
    assign latch_index = sel.nmi_sel ? 1'(LATCH_NMI) : 1'(LATCH_LPT);

    io_reg_bank #(
        .payload_t   (periph_pkg::byte_t),
        .DEPTH       (LATCH_DEPTH),
        .RESET_VALUE (periph_pkg::LATCH_RESET)
    ) u_latch_bank (
        .clock       (clock),
        .reset       (reset),
        .wr_en_i     (latch_wr),
        .wr_index_i  (latch_index),
        .wr_data_i   (data_i),
        .entries_o   (latches)
    );

    ems_mapper #(
        .ENTRIES      (EMS_ENTRIES)
    ) u_ems_mapper (
        .clock        (clock),
        .reset        (reset),
        .sel_i        (sel),
        .address_i    (address_i),
        .data_i       (data_i),
        .ems_base_i   (ems_base_i),
        .entries_o    (ems_entries),
        .ems_window_o (ems_window_o)
    );

    readback_mux #(
        .ENTRIES                     (EMS_ENTRIES)
    ) u_readback_mux (
        .clock                       (clock),
        .reset                       (reset),
        .sel_i                       (sel),
        .address_i                   (address_i),
        .ems_entries_i               (ems_entries),
        .lpt_i                       (latches[LATCH_LPT]),
        .nmi_i                       (latches[LATCH_NMI]),
        .data_bus_out_o              (data_bus_out_o),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o)
    );

endmodule

/* periph_chk.sv */
//##########################################################################
// Concurrent checks on the peripheral block outputs, bound to the top
//##########################################################################

`timescale 1ns/1ps

module periph_chk #(
    parameter int ENTRIES = 4
) (
    input logic               clock,
    input logic               reset,
    input logic               io_read_n_i,
    input logic               io_write_n_i,
    input logic [ENTRIES-1:0] ems_window_o,
    input logic               data_bus_out_from_chipset_o
);

    // Read-back flag only follows a read strobe
    flag_after_read: assert property (@(posedge clock) disable iff (reset)
        io_read_n_i |=> !data_bus_out_from_chipset_o)
        else $error("read-back flag set after a cycle without a read strobe");

    window_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(ems_window_o))
        else $error("more than one EMS window strobe active");

    // Memory windows stay closed during I/O cycles
    window_not_io: assert property (@(posedge clock) disable iff (reset)
        !(io_read_n_i && io_write_n_i) |-> (ems_window_o == '0))
        else $error("EMS window strobe active during an I/O cycle");

endmodule

bind periph_top periph_chk #(
    .ENTRIES                     (EMS_ENTRIES)
) u_periph_chk (
    .clock                       (clock),
    .reset                       (reset),
    .io_read_n_i                 (io_read_n_i),
    .io_write_n_i                (io_write_n_i),
    .ems_window_o                (ems_window_o),
    .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o)
);

/* tb_periph_top.sv */
//##########################################################################
// Testbench for the XT peripheral block
// Table of I/O and memory cycles with expected selects, strobes and
// read-back, then LFSR driven latch, EMS and block select rounds
//##########################################################################

`timescale 1ns/1ps

module tb_periph_top;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int RAND_ROUNDS  = 8;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_PROBE} op_e;

    // Address enable and configuration levels of one row
    typedef struct packed {
        logic       aen_n;
        logic       ems_en;
        logic [1:0] ems_base;
        logic       tandy;
    } ctrl_t;

    // For a read, data holds the expected read-back
    typedef struct packed {
        op_e               kind;
        periph_pkg::addr_t addr;
        periph_pkg::byte_t data;
        ctrl_t             ctrl;
        logic              exp_flag;
        logic [7:0]        exp_blk_n;
        logic [3:0]        exp_win;
    } row_t;

    localparam ctrl_t CPU    = '{1'b0, 1'b1, 2'b00, 1'b1};
    localparam ctrl_t NO_TDY = '{1'b0, 1'b1, 2'b00, 1'b0};
    localparam ctrl_t NO_EMS = '{1'b0, 1'b0, 2'b00, 1'b1};
    localparam ctrl_t DMA    = '{1'b1, 1'b1, 2'b00, 1'b1};
    localparam ctrl_t WIN_C  = '{1'b0, 1'b1, 2'b01, 1'b1};
    localparam ctrl_t WIN_D  = '{1'b0, 1'b1, 2'b10, 1'b1};
    localparam ctrl_t WIN_D3 = '{1'b0, 1'b1, 2'b11, 1'b1};

    logic                   clock;
    logic                   reset;
    periph_pkg::addr_t      address;
    logic                   address_enable_n;
    logic                   io_read_n;
    logic                   io_write_n;
    periph_pkg::byte_t      data;
    logic                   ems_enabled;
    logic [1:0]             ems_base;
    logic                   tandy_video;
    logic [7:0]             blk_sel_n;
    logic [3:0]             ems_window;
    periph_pkg::byte_t      data_bus_out;
    logic                   from_chipset;

    row_t                   rows[$];
    periph_pkg::ems_entry_t ems_model [periph_pkg::EMS_ENTRIES];
    logic [31:0]            lfsr_state    = 32'hde12;
    int                     cycle_count   = 0;
    int                     timeout_limit = 100;

    periph_top #(
        .EMS_ENTRIES                 (periph_pkg::EMS_ENTRIES)
    ) dut0 (
        .clock                       (clock),
        .reset                       (reset),
        .address_i                   (address),
        .address_enable_n_i          (address_enable_n),
        .io_read_n_i                 (io_read_n),
        .io_write_n_i                (io_write_n),
        .data_i                      (data),
        .ems_enabled_i               (ems_enabled),
        .ems_base_i                  (ems_base),
        .tandy_video_i               (tandy_video),
        .blk_sel_n_o                 (blk_sel_n),
        .ems_window_o                (ems_window),
        .data_bus_out_o              (data_bus_out),
        .data_bus_out_from_chipset_o (from_chipset)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout after %0d clock cycles", cycle_count);
            $display("Simulation failed");
            $fatal(1, "run did not finish in time");
        end
    end

    task automatic report_mismatch(input int num, input string what,
                                   input logic [11:0] expected, input logic [11:0] got);
        $display("ERR %0t: row %0d %s expected %h got %h", $time, num, what, expected, got);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    // Galois LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
    task automatic take_bits(input int n, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[6:0], lfsr_state[0]};
            lfsr_state = {1'b0, lfsr_state[31:1]}
                       ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
    endtask

    // FFh unmaps, below 80h maps the page, the rest keeps the entry
    function automatic periph_pkg::ems_entry_t ems_next(periph_pkg::ems_entry_t cur,
                                                        periph_pkg::byte_t wdata);
        if (wdata == 8'hFF)
            return '{ena: 1'b0, page: 7'h7F};
        else if (wdata < 8'h80)
            return '{ena: 1'b1, page: wdata[6:0]};
        else
            return cur;
    endfunction

    function automatic periph_pkg::byte_t ems_read_value(periph_pkg::ems_entry_t e);
        return e.ena ? {1'b0, e.page} : 8'hFF;
    endfunction

    function automatic row_t make_row(op_e kind, periph_pkg::addr_t addr,
                                      periph_pkg::byte_t d, ctrl_t ctrl, logic flag,
                                      logic [7:0] blk_n, logic [3:0] win);
        return '{kind, addr, d, ctrl, flag, blk_n, win};
    endfunction

    function automatic void add_row(op_e kind, periph_pkg::addr_t addr,
                                    periph_pkg::byte_t d, ctrl_t ctrl, logic flag,
                                    logic [7:0] blk_n, logic [3:0] win);
        rows.push_back(make_row(kind, addr, d, ctrl, flag, blk_n, win));
    endfunction

    function automatic void load_table();
        // Reset values
        add_row(OP_READ,  20'h00378, 8'hFF, CPU,    1'b1, 8'hFF, 4'h0);
        add_row(OP_READ,  20'h000A0, 8'hFF, CPU,    1'b1, 8'hDF, 4'h0);
        add_row(OP_READ,  20'h00263, 8'hFF, CPU,    1'b1, 8'hFF, 4'h0);
        add_row(OP_PROBE, 20'hAC000, 8'h00, CPU,    1'b0, 8'hFF, 4'h0);
        // Block selects with nothing to read back
        add_row(OP_READ,  20'h00000, 8'h00, CPU,    1'b0, 8'hFE, 4'h0);
        add_row(OP_WRITE, 20'h00040, 8'h55, CPU,    1'b0, 8'hFB, 4'h0);
        add_row(OP_READ,  20'h000E0, 8'h00, CPU,    1'b0, 8'h7F, 4'h0);
        add_row(OP_READ,  20'h000A4, 8'h00, NO_TDY, 1'b0, 8'hDF, 4'h0);
        add_row(OP_READ,  20'h00120, 8'h00, CPU,    1'b0, 8'hFF, 4'h0);
        add_row(OP_READ,  20'h00020, 8'h00, DMA,    1'b0, 8'hFF, 4'h0);
        // LPT and NMI latches
        add_row(OP_WRITE, 20'h00378, 8'h5A, CPU,    1'b0, 8'hFF, 4'h0);
        add_row(OP_READ,  20'h00378, 8'h5A, CPU,    1'b1, 8'hFF, 4'h0);
        add_row(OP_WRITE, 20'h000A0, 8'h3C, CPU,    1'b0, 8'hDF, 4'h0);
        add_row(OP_READ,  20'h000A7, 8'h3C, CPU,    1'b1, 8'hDF, 4'h0);
        // EMS page entries
        add_row(OP_WRITE, 20'h00260, 8'h05, CPU,    1'b0, 8'hFF, 4'h0);
        add_row(OP_WRITE, 20'h00261, 8'h7F, CPU,    1'b0, 8'hFF, 4'h0);
        add_row(OP_WRITE, 20'h00262, 8'h00, CPU,    1'b0, 8'hFF, 4'h0);
        add_row(OP_WRITE, 20'h00263, 8'h12, CPU,    1'b0, 8'hFF, 4'h0);
        add_row(OP_READ,  20'h00260, 8'h05, CPU,    1'b1, 8'hFF, 4'h0);
        add_row(OP_READ,  20'h00261, 8'h7F, CPU,    1'b1, 8'hFF, 4'h0);
        add_row(OP_READ,  20'h00262, 8'h00, CPU,    1'b1, 8'hFF, 4'h0);
        add_row(OP_READ,  20'h00263, 8'h12, CPU,    1'b1, 8'hFF, 4'h0);
        add_row(OP_WRITE, 20'h00261, 8'h80, CPU,    1'b0, 8'hFF, 4'h0);
        add_row(OP_READ,  20'h00261, 8'h7F, CPU,    1'b1, 8'hFF, 4'h0);
        add_row(OP_WRITE, 20'h00262, 8'hFF, CPU,    1'b0, 8'hFF, 4'h0);
        add_row(OP_READ,  20'h00262, 8'hFF, CPU,    1'b1, 8'hFF, 4'h0);
        add_row(OP_WRITE, 20'h00262, 8'h2A, NO_EMS, 1'b0, 8'hFF, 4'h0);
        add_row(OP_READ,  20'h00262, 8'h00, NO_EMS, 1'b0, 8'hFF, 4'h0);
        add_row(OP_READ,  20'h00262, 8'hFF, CPU,    1'b1, 8'hFF, 4'h0);
        add_row(OP_WRITE, 20'h00262, 8'h33, CPU,    1'b0, 8'hFF, 4'h0);
        add_row(OP_READ,  20'h00262, 8'h33, CPU,    1'b1, 8'hFF, 4'h0);
        // One 16 KB memory window page per entry
        add_row(OP_PROBE, 20'hA0000, 8'h00, CPU,    1'b0, 8'hFF, 4'h1);
        add_row(OP_PROBE, 20'hA7FFF, 8'h00, CPU,    1'b0, 8'hFF, 4'h2);
        add_row(OP_PROBE, 20'hA8000, 8'h00, CPU,    1'b0, 8'hFF, 4'h4);
        add_row(OP_PROBE, 20'hAFFFF, 8'h00, CPU,    1'b0, 8'hFF, 4'h8);
        add_row(OP_PROBE, 20'hC0000, 8'h00, CPU,    1'b0, 8'hFF, 4'h0);
        add_row(OP_PROBE, 20'hC0000, 8'h00, WIN_C,  1'b0, 8'hFF, 4'h1);
        add_row(OP_PROBE, 20'hC4000, 8'h00, WIN_C,  1'b0, 8'hFF, 4'h2);
        add_row(OP_PROBE, 20'hC8000, 8'h00, WIN_C,  1'b0, 8'hFF, 4'h4);
        add_row(OP_PROBE, 20'hCC000, 8'h00, WIN_C,  1'b0, 8'hFF, 4'h8);
        add_row(OP_PROBE, 20'hA4000, 8'h00, WIN_C,  1'b0, 8'hFF, 4'h0);
        add_row(OP_PROBE, 20'hD0000, 8'h00, WIN_D,  1'b0, 8'hFF, 4'h1);
        add_row(OP_PROBE, 20'hD4000, 8'h00, WIN_D,  1'b0, 8'hFF, 4'h2);
        add_row(OP_PROBE, 20'hD8000, 8'h00, WIN_D,  1'b0, 8'hFF, 4'h4);
        add_row(OP_PROBE, 20'hDC000, 8'h00, WIN_D,  1'b0, 8'hFF, 4'h8);
        add_row(OP_PROBE, 20'hC8000, 8'h00, WIN_D,  1'b0, 8'hFF, 4'h0);
        add_row(OP_PROBE, 20'hD0000, 8'h00, WIN_D3, 1'b0, 8'hFF, 4'h1);
        add_row(OP_PROBE, 20'hD4000, 8'h00, WIN_D3, 1'b0, 8'hFF, 4'h2);
        add_row(OP_PROBE, 20'hD8000, 8'h00, WIN_D3, 1'b0, 8'hFF, 4'h4);
        add_row(OP_PROBE, 20'hDC000, 8'h00, WIN_D3, 1'b0, 8'hFF, 4'h8);
        add_row(OP_PROBE, 20'hAC000, 8'h00, WIN_D3, 1'b0, 8'hFF, 4'h0);
        // Window closed during an I/O cycle and after an unmap
        add_row(OP_READ,  20'hA0000, 8'h00, CPU,    1'b0, 8'hFE, 4'h0);
        add_row(OP_WRITE, 20'h00261, 8'hFF, CPU,    1'b0, 8'hFF, 4'h0);
        add_row(OP_PROBE, 20'hA4000, 8'h00, CPU,    1'b0, 8'hFF, 4'h0);
    endfunction

    // Called and returns on a falling edge
    task automatic apply_row(input row_t r, input int num);
        address          = r.addr;
        data             = r.data;
        address_enable_n = r.ctrl.aen_n;
        ems_enabled      = r.ctrl.ems_en;
        ems_base         = r.ctrl.ems_base;
        tandy_video      = r.ctrl.tandy;
        io_write_n       = (r.kind != OP_WRITE);
        io_read_n        = (r.kind != OP_READ);
        @(negedge clock);
        // Inputs still held and read data registered on the edge in between
        assert (blk_sel_n == r.exp_blk_n && ems_window == r.exp_win) else
            report_mismatch(num, "selects/windows", {r.exp_blk_n, r.exp_win},
                            {blk_sel_n, ems_window});
        if (r.kind == OP_READ) begin
            assert (from_chipset == r.exp_flag && data_bus_out == r.data) else
                report_mismatch(num, "flag/read-back", {3'b000, r.exp_flag, r.data},
                                {3'b000, from_chipset, data_bus_out});
        end
        io_write_n = 1'b1;
        io_read_n  = 1'b1;
        // EMS commit takes two edges
        if (r.kind == OP_WRITE) begin
            repeat (2) @(negedge clock);
        end
    endtask

    task automatic track_ems(input row_t r);
        if (r.kind == OP_WRITE && r.ctrl.ems_en && !r.ctrl.aen_n
                && r.addr[15:2] == 14'h0098) begin
            ems_model[r.addr[1:0]] = ems_next(ems_model[r.addr[1:0]], r.data);
        end
    endtask

    task automatic run_random_rounds(input int first_num);
        periph_pkg::byte_t rdata;
        logic [7:0]        pick;
        periph_pkg::addr_t ems_port;
        int                num;
        for (int r = 0; r < RAND_ROUNDS; r++) begin
            num = first_num + r;
            take_bits(8, rdata);
            apply_row(make_row(OP_WRITE, 20'h00378, rdata, CPU, 1'b0, 8'hFF, 4'h0), num);
            apply_row(make_row(OP_READ, 20'h00378, rdata, CPU, 1'b1, 8'hFF, 4'h0), num);
            take_bits(8, rdata);
            take_bits(2, pick);
            ems_port = {18'h00098, pick[1:0]};
            ems_model[pick[1:0]] = ems_next(ems_model[pick[1:0]], rdata);
            apply_row(make_row(OP_WRITE, ems_port, rdata, CPU, 1'b0, 8'hFF, 4'h0), num);
            apply_row(make_row(OP_READ, ems_port, ems_read_value(ems_model[pick[1:0]]),
                               CPU, 1'b1, 8'hFF, 4'h0), num);
            // Any port below 100h with nothing there to read back
            take_bits(8, pick);
            apply_row(make_row(OP_READ, {12'h000, pick}, 8'h00, NO_TDY, 1'b0,
                               ~(8'h01 << pick[7:5]), 4'h0), num);
        end
    endtask

    initial begin
        address          = '0;
        address_enable_n = 1'b1;
        io_read_n        = 1'b1;
        io_write_n       = 1'b1;
        data             = '0;
        ems_enabled      = 1'b0;
        ems_base         = 2'b00;
        tandy_video      = 1'b0;
        reset            = 1'b1;
        for (int i = 0; i < periph_pkg::EMS_ENTRIES; i++) begin
            ems_model[i] = '0;
        end
        load_table();
        timeout_limit = rows.size() * 4 + 100;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i], i);
            track_ems(rows[i]);
        end
        run_random_rounds(rows.size());
        $display("Simulation passed");
        $finish;
    end

endmodule

/* vlog.f */
periph_pkg.sv
port_decode.sv
io_reg_bank.sv
ems_mapper.sv
readback_mux.sv
periph_top.sv
periph_chk.sv
tb_periph_top.sv

/* Makefile */
# Verilator build and run of the XT peripheral block testbench

VERILATOR ?= verilator
TOP       ?= tb_periph_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# The log decides the result, the run stops at the first error
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
